/* logic/z80CyclePkg.sv */
package z80CyclePkg;

    //------------------------------------------------------------
    // Machine cycle kinds
    //------------------------------------------------------------
    typedef enum logic [2:0] {
        KIND_NONE    = 3'd0,    // No cycle in progress
        KIND_FETCH   = 3'd1,    // Opcode fetch (M1)
        KIND_MREAD   = 3'd2,    // Memory read
        KIND_MWRITE  = 3'd3,    // Memory write
        KIND_IOREAD  = 3'd4,    // I/O read
        KIND_IOWRITE = 3'd5,    // I/O write
        KIND_INTR    = 3'd6     // Interrupt response
    } cycleKind_t;

    // One-hot T-state, bit 0 is T1
    typedef logic [5:0] tState_t;

    localparam tState_t T1 = 6'b000001;
    localparam tState_t T2 = 6'b000010;
    localparam tState_t T3 = 6'b000100;
    localparam tState_t T4 = 6'b001000;
    localparam tState_t T5 = 6'b010000;
    localparam tState_t T6 = 6'b100000;

    // Sequencer FSM
    typedef enum logic {
        SEQ_IDLE    = 1'b0,
        SEQ_RUNNING = 1'b1
    } seqState_t;

    // Last T-state of each kind, where BUSRQ is tested
    function automatic tState_t lastState(cycleKind_t kind);
        case (kind)
            KIND_FETCH:                lastState = T4;
            KIND_MREAD, KIND_MWRITE:   lastState = T3;
            KIND_IOREAD, KIND_IOWRITE: lastState = T4;
            KIND_INTR:                 lastState = T6;
            default:                   lastState = '0;
        endcase
    endfunction

    // T-state in which WAIT stretches the cycle
    function automatic tState_t waitState(cycleKind_t kind);
        case (kind)
            KIND_FETCH, KIND_MREAD, KIND_MWRITE: waitState = T2;
            KIND_IOREAD, KIND_IOWRITE:           waitState = T3;
            KIND_INTR:                           waitState = T4;
            default:                             waitState = '0;
        endcase
    endfunction

endpackage

/* logic/z80PadPkg.sv */
package z80PadPkg;

    //------------------------------------------------------------
    // External bus widths
    //------------------------------------------------------------
    localparam int ADDR_BITS = 16;     // A15..A0
    localparam int DATA_BITS = 8;      // D7..D0

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;

    //------------------------------------------------------------
    // Control pins, all active high inside the core
    //------------------------------------------------------------
    typedef struct packed {
        logic m1;           // Opcode fetch or interrupt acknowledge
        logic mreq;         // Memory request
        logic iorq;         // I/O request
        logic rd;           // Read strobe
        logic wr;           // Write strobe
        logic rfsh;         // Refresh slot
        logic busAck;       // Bus granted to an external master
    } busPins_t;

    //------------------------------------------------------------
    // Pad controls from pin control to the pads
    //------------------------------------------------------------
    typedef struct packed {
        logic busPinOe;     // Drive the control pins
        logic abPinOe;      // Drive the address pins
        logic abWe;         // Load the address latch
        logic dbPinOe;      // Drive the data pins from the latch
        logic dbPinRe;      // Capture the data pins into the latch
        logic dbWe;         // Load the latch from internal write data
        logic dbOe;         // Hand the latch to the internal bus
    } padCtl_t;

endpackage

/* logic/machineCycleSequencer.sv */
`timescale 1ns/1ps

module machineCycleSequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cycleStart,     // One-clk start strobe
    input  z80CyclePkg::cycleKind_t cycleKind,      // Kind of cycle to start
    input  logic                    hold,           // Repeat the current T-state
    input  logic                    busAck,         // Bus granted away, freeze
    output z80CyclePkg::tState_t    tState,
    output logic                    phaseHigh,      // First half of the T-state
    output z80CyclePkg::cycleKind_t activeKind,     // Kind of the running cycle
    output logic                    cycleDone,
    output logic                    ready
);

    z80CyclePkg::seqState_t seqState;
    logic                   startAccept;
    logic                   inLastT;
    logic                   running;

    assign running = (seqState == z80CyclePkg::SEQ_RUNNING);
    assign ready   = (seqState == z80CyclePkg::SEQ_IDLE);

    // A start without a kind is dropped
    assign startAccept = cycleStart & ready & (cycleKind != z80CyclePkg::KIND_NONE);

    assign inLastT = (tState == z80CyclePkg::lastState(activeKind));

    // Low phase of the final T-state, nothing stretching it
    assign cycleDone = running & ~phaseHigh & inLastT & ~hold;

    //------------------------------------------------------------
    // T-state and phase stepping
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            seqState   <= z80CyclePkg::SEQ_IDLE;
            tState     <= '0;
            phaseHigh  <= 1'b0;
            activeKind <= z80CyclePkg::KIND_NONE;
        end else begin
            case (seqState)
                z80CyclePkg::SEQ_IDLE: begin
                    if (startAccept) begin
                        seqState   <= z80CyclePkg::SEQ_RUNNING;
                        activeKind <= cycleKind;
                        tState     <= z80CyclePkg::T1;
                        phaseHigh  <= 1'b1;         // T1 starts in its high half
                    end
                end
                z80CyclePkg::SEQ_RUNNING: begin
                    if (!busAck) begin              // Frozen while the bus is granted
                        if (phaseHigh) begin
                            phaseHigh <= 1'b0;
                        end else if (hold) begin
                            phaseHigh <= 1'b1;      // Same T-state again, both halves
                        end else if (inLastT) begin
                            seqState   <= z80CyclePkg::SEQ_IDLE;
                            tState     <= '0;
                            activeKind <= z80CyclePkg::KIND_NONE;
                        end else begin
                            tState    <= tState << 1;   // Next T-state
                            phaseHigh <= 1'b1;
                        end
                    end
                end
                default: seqState <= z80CyclePkg::SEQ_IDLE;
            endcase
        end
    end

    //------------------------------------------------------------
    // Checks
    //------------------------------------------------------------
    // Exactly one T-state while a cycle runs
    tStateOneHot: assert property (@(posedge clk) disable iff (reset)
        running |-> $onehot(tState))
        else $error("tState not one-hot: %b", tState);

    // Core must wait for ready before the next start
    startWhileBusy: assert property (@(posedge clk) disable iff (reset)
        cycleStart |-> ready)
        else $error("cycleStart while a cycle is running");

endmodule

/* logic/pinControl.sv */
`timescale 1ns/1ps

module pinControl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mwait,          // External device not ready
    input  logic                    busrq,          // External master wants the bus
    input  z80CyclePkg::tState_t    tState,
    input  logic                    phaseHigh,
    input  z80CyclePkg::cycleKind_t activeKind,
    output z80PadPkg::busPins_t     pins,
    output z80PadPkg::padCtl_t      padCtl,
    output logic                    hold,           // Stretch the current T-state
    output logic                    busAck
);

    logic t1, t2, t3, t4, t5, t6;
    logic hi, lo;
    logic running;
    logic inLastT;
    logic inWaitT;
    logic busPinOe;
    logic waitLatch;                    // WAIT seen at the start of the low phase
    logic busrqLatch;                   // BUSRQ seen every clk
    z80PadPkg::busPins_t rawPins;       // Decoded pins before bus release
    z80PadPkg::padCtl_t  rawCtl;        // Decoded pad strobes

    assign t1 = tState[0];
    assign t2 = tState[1];
    assign t3 = tState[2];
    assign t4 = tState[3];
    assign t5 = tState[4];
    assign t6 = tState[5];
    assign hi = phaseHigh;
    assign lo = ~phaseHigh;

    //------------------------------------------------------------
    // Pin and pad strobe decode per kind
    //------------------------------------------------------------
    always_comb begin
        rawPins = '0;
        rawCtl  = '0;
        case (activeKind)
            z80CyclePkg::KIND_FETCH: begin
                rawPins.m1   = t1 | t2;
                rawPins.mreq = (t1 & lo) | t2 | (t3 & lo) | (t4 & hi);
                rawPins.rd   = (t1 & lo) | t2;
                rawPins.rfsh = t3 | t4;                 // Refresh slot
                rawCtl.abWe    = (t1 | t3) & hi;        // Reload for refresh address
                rawCtl.dbPinRe = t2;
                rawCtl.dbOe    = t3;
            end
            z80CyclePkg::KIND_MREAD: begin
                rawPins.mreq = (t1 & lo) | t2 | (t3 & hi);
                rawPins.rd   = (t1 & lo) | t2 | (t3 & hi);
                rawCtl.abWe    = t1 & hi;
                rawCtl.dbPinRe = t3 & hi;
                rawCtl.dbOe    = t3 & lo;
            end
            z80CyclePkg::KIND_MWRITE: begin
                rawPins.mreq = (t1 & lo) | t2 | (t3 & hi);
                rawPins.wr   = (t2 & lo) | (t3 & hi);   // Data settles before wr
                rawCtl.abWe    = t1 & hi;
                rawCtl.dbWe    = t1 & hi;
                rawCtl.dbPinOe = (t1 & lo) | t2 | t3;
            end
            z80CyclePkg::KIND_IOREAD: begin
                rawPins.iorq = t2 | t3 | (t4 & hi);
                rawPins.rd   = t2 | t3 | (t4 & hi);
                rawCtl.abWe    = t1 & hi;
                rawCtl.dbPinRe = t4 & hi;
                rawCtl.dbOe    = t4 & lo;
            end
            z80CyclePkg::KIND_IOWRITE: begin
                rawPins.iorq = t2 | t3 | (t4 & hi);
                rawPins.wr   = t2 | t3 | (t4 & hi);
                rawCtl.abWe    = t1 & hi;
                rawCtl.dbWe    = t1 & hi;
                rawCtl.dbPinOe = (t1 & lo) | t2 | t3 | t4;
            end
            z80CyclePkg::KIND_INTR: begin
                // Two automatic waits before iorq, then refresh
                rawPins.m1   = t1 | t2 | t3 | t4;
                rawPins.iorq = (t3 & lo) | t4;
                rawPins.mreq = (t5 & lo) | t6;
                rawPins.rfsh = t5 | t6;
                rawCtl.abWe    = (t1 | t5) & hi;
                rawCtl.dbPinRe = t4 & lo;               // Vector from the device
                rawCtl.dbOe    = t5;
            end
            default: begin
                rawPins = '0;
                rawCtl  = '0;
            end
        endcase
    end

    //------------------------------------------------------------
    // WAIT and BUSRQ sampling
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            waitLatch  <= 1'b0;
            busrqLatch <= 1'b0;
        end else begin
            busrqLatch <= busrq;
            if (phaseHigh) begin
                waitLatch <= mwait;     // Edge into the low phase
            end
        end
    end

    assign running = (activeKind != z80CyclePkg::KIND_NONE);
    assign inLastT = running & (tState == z80CyclePkg::lastState(activeKind));
    assign inWaitT = running & (tState == z80CyclePkg::waitState(activeKind));

    assign busAck = busrqLatch & inLastT;           // Grant only at the cycle end
    assign hold   = (waitLatch & inWaitT) | busAck;

    // Pins are driven only inside a cycle that owns the bus
    assign busPinOe = running & ~busAck;

    always_comb begin
        pins = rawPins;
        if (!busPinOe) begin
            pins = '0;
        end
        pins.busAck = busAck;
    end

    always_comb begin
        padCtl          = rawCtl;
        padCtl.busPinOe = busPinOe;
        padCtl.abPinOe  = busPinOe;
        padCtl.dbPinOe  = rawCtl.dbPinOe & ~busAck;     // Release data pins too
    end

    // Read and write strobes are exclusive in every kind
    rdWrExclusive: assert property (@(posedge clk) disable iff (reset)
        !(pins.rd && pins.wr))
        else $error("rd and wr both high, kind %0d", activeKind);

endmodule

/* logic/addressPad.sv */
`timescale 1ns/1ps

module addressPad #(
    parameter int ADDR_WIDTH = $bits(z80PadPkg::addr_t)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  z80PadPkg::padCtl_t     padCtl,
    input  z80PadPkg::addr_t       cycleAddress,   // Also used in refresh slots
    output logic [ADDR_WIDTH-1:0]  addressPins,
    output logic                   addressPinsOe
);

    logic [ADDR_WIDTH-1:0] addressLatch;   // Output pin latch

    //------------------------------------------------------------
    // Latch load
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            addressLatch <= '0;
        end else if (padCtl.abWe) begin
            addressLatch <= ADDR_WIDTH'(cycleAddress);  // T1H, refresh T-state H
        end
    end

    // Released bus reads as zero
    assign addressPins   = padCtl.abPinOe ? addressLatch : '0;
    assign addressPinsOe = padCtl.abPinOe;

endmodule

/* logic/dataPad.sv */
`timescale 1ns/1ps

module dataPad #(
    parameter int DATA_WIDTH = $bits(z80PadPkg::data_t)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  z80PadPkg::padCtl_t     padCtl,
    input  logic [DATA_WIDTH-1:0]  writeData,      // From the core
    input  logic [DATA_WIDTH-1:0]  dataPinsIn,     // From the external bus
    output logic [DATA_WIDTH-1:0]  dataPinsOut,
    output logic                   dataPinsOe,
    output logic [DATA_WIDTH-1:0]  readData,       // Valid while readStrobe
    output logic                   readStrobe
);

    logic [DATA_WIDTH-1:0] dataLatch;  // Shared by both directions

    //------------------------------------------------------------
    // Latch, loaded from inside or from the pins
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (padCtl.dbWe) begin
            dataLatch <= writeData;         // Write cycles, T1H
        end else if (padCtl.dbPinRe) begin
            dataLatch <= dataPinsIn;        // Read cycles, sampled off the bus
        end
    end

    // Pin side
    assign dataPinsOut = padCtl.dbPinOe ? dataLatch : '0;
    assign dataPinsOe  = padCtl.dbPinOe;

    // Core side
    assign readData   = dataLatch;
    assign readStrobe = padCtl.dbOe;

    // Both loads come from pin control and must never collide
    latchLoadExclusive: assert property (@(posedge clk) disable iff (reset)
        !(padCtl.dbWe && padCtl.dbPinRe))
        else $error("dbWe and dbPinRe both high");

endmodule

/* logic/busInterfaceTop.sv */
`timescale 1ns/1ps

module busInterfaceTop #(
    parameter int ADDR_WIDTH = $bits(z80PadPkg::addr_t),
    parameter int DATA_WIDTH = $bits(z80PadPkg::data_t)
) (
    input  logic                    clk,
    input  logic                    reset,
    // Core side
    input  logic                    cycleStart,
    input  z80CyclePkg::cycleKind_t cycleKind,
    input  z80PadPkg::addr_t        cycleAddress,
    input  logic [DATA_WIDTH-1:0]   writeData,
    output logic [DATA_WIDTH-1:0]   readData,
    output logic                    readStrobe,
    output logic                    cycleDone,
    output logic                    ready,
    // External bus
    input  logic                    mwait,
    input  logic                    busrq,
    input  logic [DATA_WIDTH-1:0]   dataPinsIn,
    output z80PadPkg::busPins_t     pins,
    output logic [ADDR_WIDTH-1:0]   addressPins,
    output logic                    addressPinsOe,
    output logic [DATA_WIDTH-1:0]   dataPinsOut,
    output logic                    dataPinsOe
);

    z80CyclePkg::tState_t    tState;
    z80CyclePkg::cycleKind_t activeKind;
    z80PadPkg::padCtl_t      padCtl;
    logic                    phaseHigh;
    logic                    hold;
    logic                    busAck;

    //------------------------------------------------------------
    // Timing and decode
    //------------------------------------------------------------
    machineCycleSequencer sequencer (
        .clk(clk), .reset(reset),
        .cycleStart(cycleStart), .cycleKind(cycleKind),
        .hold(hold), .busAck(busAck),
        .tState(tState), .phaseHigh(phaseHigh), .activeKind(activeKind),
        .cycleDone(cycleDone), .ready(ready)
    );

    pinControl control (
        .clk(clk), .reset(reset),
        .mwait(mwait), .busrq(busrq),
        .tState(tState), .phaseHigh(phaseHigh), .activeKind(activeKind),
        .pins(pins), .padCtl(padCtl),
        .hold(hold), .busAck(busAck)
    );

    //------------------------------------------------------------
    // Pads
    //------------------------------------------------------------
    addressPad #(.ADDR_WIDTH(ADDR_WIDTH)) addrPad (
        .clk(clk), .reset(reset), .padCtl(padCtl),
        .cycleAddress(cycleAddress),
        .addressPins(addressPins), .addressPinsOe(addressPinsOe)
    );

    dataPad #(.DATA_WIDTH(DATA_WIDTH)) dataBusPad (
        .clk(clk), .reset(reset), .padCtl(padCtl),
        .writeData(writeData), .dataPinsIn(dataPinsIn),
        .dataPinsOut(dataPinsOut), .dataPinsOe(dataPinsOe),
        .readData(readData), .readStrobe(readStrobe)
    );

endmodule

/* bench/busInterfaceBench.sv */
`timescale 1ns/1ps

module busInterfaceBench;

    logic                    clk;
    logic                    reset;
    logic                    cycleStart;
    z80CyclePkg::cycleKind_t cycleKind;
    z80PadPkg::addr_t        cycleAddress;
    z80PadPkg::data_t        writeData;
    logic                    mwait;
    logic                    busrq;
    z80PadPkg::data_t        dataPinsIn;
    z80PadPkg::busPins_t     pins;
    z80PadPkg::addr_t        addressPins;
    logic                    addressPinsOe;
    z80PadPkg::data_t        dataPinsOut;
    logic                    dataPinsOe;
    z80PadPkg::data_t        readData;
    logic                    readStrobe;
    logic                    cycleDone;
    logic                    ready;

    int trKind[64];                 // Trace columns
    int trAddr[64];
    int trData[64];
    int trWaits[64];
    int trBusrq[64];
    int trExpect[64];
    int trCount;
    int errorCount;
    int seed;
    int limitClks;                  // Watchdog budget
    bit traceLoaded;

    busInterfaceTop #(.ADDR_WIDTH(16), .DATA_WIDTH(8)) uut (
        .clk(clk), .reset(reset), .cycleStart(cycleStart), .cycleKind(cycleKind),
        .cycleAddress(cycleAddress), .writeData(writeData), .readData(readData),
        .readStrobe(readStrobe), .cycleDone(cycleDone), .ready(ready),
        .mwait(mwait), .busrq(busrq), .dataPinsIn(dataPinsIn), .pins(pins),
        .addressPins(addressPins), .addressPinsOe(addressPinsOe),
        .dataPinsOut(dataPinsOut), .dataPinsOe(dataPinsOe)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    //------------------------------------------------------------
    // Reference table, one entry per kind, T-state and half
    //------------------------------------------------------------
    function automatic z80PadPkg::busPins_t tablePins(input int kind, input int t, input bit hi);
        z80PadPkg::busPins_t p;
        p = '0;
        case (kind)
            1: begin                                    // Opcode fetch
                p.m1   = (t <= 2);
                p.mreq = (t == 1 && !hi) || t == 2 || (t == 3 && !hi) || (t == 4 && hi);
                p.rd   = (t == 1 && !hi) || t == 2;
                p.rfsh = (t >= 3);
            end
            2, 3: begin                                 // Memory read or write
                p.mreq = (t == 1 && !hi) || t == 2 || (t == 3 && hi);
                if (kind == 2) p.rd = p.mreq;
                else p.wr = (t == 2 && !hi) || (t == 3 && hi);
            end
            4, 5: begin                                 // I/O read or write
                p.iorq = t == 2 || t == 3 || (t == 4 && hi);
                if (kind == 4) p.rd = p.iorq;
                else p.wr = p.iorq;
            end
            6: begin                                    // Interrupt response
                p.m1   = (t <= 4);
                p.iorq = (t == 3 && !hi) || t == 4;
                p.mreq = (t == 5 && !hi) || t == 6;
                p.rfsh = (t >= 5);
            end
            default: p = '0;
        endcase
        return p;
    endfunction

    function automatic bit tableDataOe(input int kind, input int t, input bit hi);
        if (kind == 3) return (t == 1 && !hi) || t == 2 || t == 3;
        if (kind == 5) return (t == 1 && !hi) || (t >= 2 && t <= 4);
        return 1'b0;
    endfunction

    function automatic bit tableStrobe(input int kind, input int t, input bit hi);
        case (kind)
            1:       return t == 3;
            2:       return t == 3 && !hi;
            4:       return t == 4 && !hi;
            6:       return t == 5;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int cycleLength(input int kind);
        if (kind == 6) return 6;
        if (kind == 2 || kind == 3) return 3;
        return 4;
    endfunction

    function automatic int waitTState(input int kind);
        if (kind == 6) return 4;
        if (kind == 4 || kind == 5) return 3;
        return 2;
    endfunction

    //------------------------------------------------------------
    // Checks
    //------------------------------------------------------------
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("ERR %s got %h expected %h at %0t", name, got, expected, $time);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic checkIdle();
        checkValue("pins", 32'(pins), 32'd0);
        checkValue("addressPinsOe", 32'(addressPinsOe), 32'd0);
        checkValue("dataPinsOe", 32'(dataPinsOe), 32'd0);
        checkValue("readStrobe", 32'(readStrobe), 32'd0);
        checkValue("cycleDone", 32'(cycleDone), 32'd0);
        checkValue("ready", 32'(ready), 32'd1);
    endtask

    task automatic loadTrace();
        int fd;
        int k, a, d, n, b, x;
        string line;
        fd = $fopen("bench/busCycleTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cycle trace file");
            $display("TESTS FAILED");
            $fatal(1, "No stimulus");
        end
        trCount = 0;
        limitClks = 100;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != 8'h23) begin     // Skip # lines
                if ($sscanf(line, "%h %h %h %d %d %h", k, a, d, n, b, x) == 6) begin
                    trKind[trCount] = k;
                    trAddr[trCount] = a;
                    trData[trCount] = d;
                    trWaits[trCount] = n;
                    trBusrq[trCount] = b;
                    trExpect[trCount] = x;
                    limitClks += (12 + n + b) * 2 + 4;  // Plus the idle gap
                    trCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    //------------------------------------------------------------
    // One machine cycle with the memory and I/O model
    //------------------------------------------------------------
    task automatic runCycle(input int i);
        int kind, len, w, n, b, kH, nSteps, e, t, reps;
        bit hi, ack, answered;
        int steps[$];
        z80PadPkg::busPins_t expPins;
        kind = trKind[i];
        len  = cycleLength(kind);
        w    = waitTState(kind);
        n    = trWaits[i];
        b    = trBusrq[i];
        kH   = 2 * (len + n) - 1;           // High half of the last T-state
        for (t = 1; t <= len; t++) begin
            reps = (t == w) ? n + 1 : 1;
            if (t == len) repeat (b) steps.push_back(t * 4 + 3);   // Frozen, granted
            repeat (reps) begin
                steps.push_back(t * 4 + 2);
                steps.push_back(t * 4);
            end
        end
        nSteps = steps.size();
        answered = 1'b0;
        @(posedge clk);
        cycleStart   <= 1'b1;
        cycleKind    <= z80CyclePkg::cycleKind_t'(kind);
        cycleAddress <= 16'(trAddr[i]);
        writeData    <= 8'(trData[i]);
        dataPinsIn   <= '0;
        @(negedge clk);
        checkValue("ready", 32'(ready), 32'd1);
        for (int k = 1; k <= nSteps; k++) begin
            @(posedge clk);
            cycleStart <= 1'b0;
            mwait      <= (n > 0) && (k <= 2 * w + 2 * n - 3);
            busrq      <= (b > 0) && (k >= kH - 1) && (k <= kH + b - 2);
            dataPinsIn <= answered ? 8'(trData[i]) : 8'h00;
            @(negedge clk);
            e   = steps[k - 1];
            t   = e / 4;
            hi  = e[1];
            ack = e[0];
            expPins = '0;
            expPins.busAck = 1'b1;
            if (!ack) expPins = tablePins(kind, t, hi);
            checkValue("pins", 32'(pins), 32'(expPins));
            checkValue("addressPinsOe", 32'(addressPinsOe), 32'(!ack));
            // Address latch is loaded by T1H and shown from T1L on
            if (addressPinsOe && !(t == 1 && hi)) begin
                checkValue("addressPins", 32'(addressPins), 32'(trAddr[i]));
            end
            checkValue("dataPinsOe", 32'(dataPinsOe), 32'(!ack && tableDataOe(kind, t, hi)));
            if (dataPinsOe) checkValue("dataPinsOut", 32'(dataPinsOut), 32'(trData[i]));
            checkValue("readStrobe", 32'(readStrobe), 32'(!ack && tableStrobe(kind, t, hi)));
            if (readStrobe) checkValue("readData", 32'(readData), 32'(trExpect[i]));
            checkValue("cycleDone", 32'(cycleDone), 32'(k == nSteps));
            checkValue("ready", 32'(ready), 32'd0);
            if (pins.rd || (pins.m1 && pins.iorq)) answered = 1'b1;     // Device answers
        end
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        int gap;
        seed = 32'h722d3b66;
        errorCount = 0;
        traceLoaded = 1'b0;
        reset = 1'b1;
        cycleStart = 1'b0;
        cycleKind = z80CyclePkg::KIND_NONE;
        cycleAddress = '0;
        writeData = '0;
        mwait = 1'b0;
        busrq = 1'b0;
        dataPinsIn = '0;
        loadTrace();
        traceLoaded = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkIdle();                    // State right after reset
        for (int i = 0; i < trCount; i++) begin
            gap = int'($unsigned($random(seed)) % 32'd4);
            repeat (gap) begin
                @(posedge clk);
                @(negedge clk);
                checkIdle();
            end
            runCycle(i);
        end
        // Reset in the middle of a fetch
        @(posedge clk);
        cycleStart <= 1'b1;
        cycleKind <= z80CyclePkg::KIND_FETCH;
        @(posedge clk);
        cycleStart <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkIdle();
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkIdle();
        if (errorCount == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "Errors found");
        end
    end

    // Watchdog sized from the trace
    initial begin
        wait (traceLoaded);
        #(limitClks * 8);
        $display("Watchdog expired before the trace finished");
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
    end

endmodule

/* bench/busCycleTrace.txt */
# kind(1 fetch 2 mread 3 mwrite 4 ioread 5 iowrite 6 intr) address data
# wait-states busrq-clks expected-read-data, all but waits and busrq in hex
1 0000 3e 0 0 3e
1 0100 c3 2 0 c3
2 1234 5a 0 0 5a
2 8001 a5 1 0 a5
3 4000 77 0 0 00
3 4001 81 3 0 00
4 00fe 19 0 0 19
4 0012 e4 2 0 e4
5 0034 6c 0 0 00
5 00ff 93 1 0 00
6 0038 ff 0 0 ff
6 0038 cf 1 0 cf
1 2000 76 0 3 76
2 2100 44 0 2 44
3 2200 55 1 4 00
4 0050 66 0 1 66
5 0051 88 2 2 00
6 0066 d7 0 5 d7

/* sources.f */
logic/z80CyclePkg.sv
logic/z80PadPkg.sv
logic/machineCycleSequencer.sv
logic/pinControl.sv
logic/addressPad.sv
logic/dataPad.sv
logic/busInterfaceTop.sv
bench/busInterfaceBench.sv

/* run.sh */
#!/bin/sh
# Build and run the bus interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module busInterfaceBench \
    -f sources.f -o benchSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/benchSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0
